/* Makefile */
TOP := tb_ddr_bridge

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* avalon_master.sv */
module avalon_master
  import ddr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  line_cmd_t i_cmd,
  input  logic      i_cmd_empty,
  output logic      o_cmd_pop,

  input  logic      i_avl_ready,
  input  logic      i_avl_rdata_valid,
  input  line_t     i_avl_rdata,
  output logic      o_avl_read,
  output logic      o_avl_write,
  output avl_addr_t o_avl_addr,
  output line_t     o_avl_wdata,

  output logic      o_rdata_push,
  output line_t     o_rdata
);

  avl_state_t state;

  assign o_cmd_pop = (state == AVL_IDLE) && !i_cmd_empty;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= AVL_IDLE;
      o_avl_read   <= 1'b0;
      o_avl_write  <= 1'b0;
      o_rdata_push <= 1'b0;
    end
    else
    begin
      o_rdata_push <= 1'b0;
      case (state)
        AVL_IDLE:
        begin
          if (!i_cmd_empty)
          begin
            o_avl_read  <= !i_cmd.write;
            o_avl_write <= i_cmd.write;
            state       <= AVL_ISSUE;
          end
        end
        AVL_ISSUE:
        begin
          // waitrequest keeps everything in place
          if (i_avl_ready)
          begin
            o_avl_read  <= 1'b0;
            o_avl_write <= 1'b0;
            state       <= o_avl_read ? AVL_RECEIVE : AVL_IDLE;
          end
        end
        AVL_RECEIVE:
        begin
          if (i_avl_rdata_valid)
          begin
            o_rdata_push <= 1'b1;
            state        <= AVL_IDLE;
          end
        end
        default:
          state <= AVL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (o_cmd_pop)
    begin
      // line index to byte address
      o_avl_addr  <= {i_cmd.addr, 4'b0000};
      o_avl_wdata <= i_cmd.data;
    end
    if ((state == AVL_RECEIVE) && i_avl_rdata_valid)
      o_rdata <= i_avl_rdata;
  end

  assert property (@(posedge clk) disable iff (rst) !(o_avl_read && o_avl_write))
    else $error("avalon_master: read and write together");

  // a stalled request must not change under the slave
  assert property (@(posedge clk) disable iff (rst)
    (o_avl_read || o_avl_write) && !i_avl_ready |=>
      $stable(o_avl_read) && $stable(o_avl_write) && $stable(o_avl_addr))
    else $error("avalon_master: request changed during waitrequest");

endmodule

/* ddr_bridge_top.sv */
`include "ddr_settings.svh"

module ddr_bridge_top
  import ddr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  logic       i_membus_req,
  input  logic       i_membus_write,
  input  word_t      i_membus_addr,
  input  word_t      i_membus_data,
  input  byte_mask_t i_membus_wr_mask,
  output logic       o_membus_ack,
  output word_t      o_membus_data,

  input  logic       i_avl_ready,
  input  logic       i_avl_rdata_valid,
  input  line_t      i_avl_rdata,
  output logic       o_avl_read,
  output logic       o_avl_write,
  output avl_addr_t  o_avl_addr,
  output line_t      o_avl_wdata
);

  line_cmd_t ctrl_cmd;
  line_cmd_t fifo_cmd;
  logic      cmd_push;
  logic      cmd_pop;
  logic      cmd_full;
  logic      cmd_empty;

  line_t     master_rdata;
  line_t     fifo_rdata;
  logic      rdata_push;
  logic      rdata_pop;
  logic      rdata_empty;
  // never full, one fetch outstanding at most
  logic      rdata_full;

  line_cache_ctrl line_cache_ctrl_i (
    .clk              (clk),
    .rst              (rst),
    .i_membus_req     (i_membus_req),
    .i_membus_write   (i_membus_write),
    .i_membus_addr    (i_membus_addr),
    .i_membus_data    (i_membus_data),
    .i_membus_wr_mask (i_membus_wr_mask),
    .o_membus_ack     (o_membus_ack),
    .o_membus_data    (o_membus_data),
    .i_cmd_full       (cmd_full),
    .o_cmd_push       (cmd_push),
    .o_cmd            (ctrl_cmd),
    .i_rdata          (fifo_rdata),
    .i_rdata_empty    (rdata_empty),
    .o_rdata_pop      (rdata_pop)
  );

  sync_fifo #(
    .WIDTH      ($bits(line_cmd_t)),
    .DEPTH_LOG2 (`FIFO_DEPTH_LOG2)
  ) cmd_fifo (
    .clk     (clk),
    .rst     (rst),
    .i_push  (cmd_push),
    .i_data  (ctrl_cmd),
    .i_pop   (cmd_pop),
    .o_data  (fifo_cmd),
    .o_empty (cmd_empty),
    .o_full  (cmd_full)
  );

  avalon_master avalon_master_i (
    .clk               (clk),
    .rst               (rst),
    .i_cmd             (fifo_cmd),
    .i_cmd_empty       (cmd_empty),
    .o_cmd_pop         (cmd_pop),
    .i_avl_ready       (i_avl_ready),
    .i_avl_rdata_valid (i_avl_rdata_valid),
    .i_avl_rdata       (i_avl_rdata),
    .o_avl_read        (o_avl_read),
    .o_avl_write       (o_avl_write),
    .o_avl_addr        (o_avl_addr),
    .o_avl_wdata       (o_avl_wdata),
    .o_rdata_push      (rdata_push),
    .o_rdata           (master_rdata)
  );

  sync_fifo #(
    .WIDTH      (`LINE_W),
    .DEPTH_LOG2 (`FIFO_DEPTH_LOG2)
  ) rdata_fifo (
    .clk     (clk),
    .rst     (rst),
    .i_push  (rdata_push),
    .i_data  (master_rdata),
    .i_pop   (rdata_pop),
    .o_data  (fifo_rdata),
    .o_empty (rdata_empty),
    .o_full  (rdata_full)
  );

  assert property (@(posedge clk) disable iff (rst) rdata_push |-> !rdata_full)
    else $error("ddr_bridge_top: more than one fetch outstanding");

endmodule

/* ddr_pkg.sv */
`include "ddr_settings.svh"

package ddr_pkg;

  typedef logic [`WORD_W-1:0]     word_t;
  typedef logic [`WORD_W/8-1:0]   byte_mask_t;
  typedef logic [`LINE_W-1:0]     line_t;
  // address bits 25 to 4
  typedef logic [`DDR_ADDR_W-5:0] line_addr_t;
  typedef logic [`DDR_ADDR_W-1:0] avl_addr_t;

  // write-back carries the line, a fetch carries only the index
  typedef struct packed {
    logic       write;
    line_addr_t addr;
    line_t      data;
  } line_cmd_t;

  typedef enum logic [2:0] {
    CACHE_IDLE,
    CACHE_FLUSH,
    CACHE_LOAD,
    CACHE_LOAD_WAIT,
    CACHE_UPDATE,
    CACHE_ACK_HOLD
  } cache_state_t;

  typedef enum logic [1:0] {
    AVL_IDLE,
    AVL_ISSUE,
    AVL_RECEIVE
  } avl_state_t;

endpackage

/* ddr_settings.svh */
`ifndef DDR_SETTINGS_SVH
`define DDR_SETTINGS_SVH

// byte address as seen on the Avalon side
`define DDR_ADDR_W 26

// one buffer line, one Avalon beat
`define LINE_W 128

// word bus data width
`define WORD_W 32

// both FIFOs hold four entries
`define FIFO_DEPTH_LOG2 2

`endif

/* line_cache_ctrl.sv */
`include "ddr_settings.svh"

module line_cache_ctrl
  import ddr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  logic       i_membus_req,
  input  logic       i_membus_write,
  input  word_t      i_membus_addr,
  input  word_t      i_membus_data,
  input  byte_mask_t i_membus_wr_mask,
  output logic       o_membus_ack,
  output word_t      o_membus_data,

  input  logic       i_cmd_full,
  output logic       o_cmd_push,
  output line_cmd_t  o_cmd,

  input  line_t      i_rdata,
  input  logic       i_rdata_empty,
  output logic       o_rdata_pop
);

  cache_state_t state;
  logic         buf_valid;
  line_addr_t   buf_addr;
  line_t        buf_data;
  line_addr_t   req_line;
  logic [1:0]   word_sel;
  logic         hit;

  assign req_line = i_membus_addr[`DDR_ADDR_W-1:4];
  assign word_sel = i_membus_addr[3:2];
  assign hit      = buf_valid && (buf_addr == req_line);

  // one command per cycle while there is room
  assign o_cmd_push  = ((state == CACHE_FLUSH) || (state == CACHE_LOAD)) && !i_cmd_full;
  assign o_rdata_pop = (state == CACHE_LOAD_WAIT) && !i_rdata_empty;

  always_comb
  begin
    o_cmd.write = (state == CACHE_FLUSH);
    o_cmd.addr  = (state == CACHE_FLUSH) ? buf_addr : req_line;
    o_cmd.data  = buf_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= CACHE_IDLE;
      buf_valid    <= 1'b0;
      o_membus_ack <= 1'b0;
    end
    else
    begin
      case (state)
        CACHE_IDLE:
        begin
          if (i_membus_req)
          begin
            if (hit)
              state <= CACHE_UPDATE;
            else if (buf_valid)
              state <= CACHE_FLUSH;
            else
              state <= CACHE_LOAD;
          end
        end
        CACHE_FLUSH:
        begin
          if (!i_cmd_full)
          begin
            buf_valid <= 1'b0;
            state     <= CACHE_LOAD;
          end
        end
        CACHE_LOAD:
        begin
          if (!i_cmd_full)
            state <= CACHE_LOAD_WAIT;
        end
        CACHE_LOAD_WAIT:
        begin
          if (!i_rdata_empty)
          begin
            buf_valid <= 1'b1;
            state     <= CACHE_UPDATE;
          end
        end
        CACHE_UPDATE:
        begin
          o_membus_ack <= 1'b1;
          state        <= CACHE_ACK_HOLD;
        end
        CACHE_ACK_HOLD:
        begin
          // return to zero before the next request
          if (!i_membus_req)
          begin
            o_membus_ack <= 1'b0;
            state        <= CACHE_IDLE;
          end
        end
        default:
          state <= CACHE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == CACHE_LOAD) && !i_cmd_full)
      buf_addr <= req_line;
    if (o_rdata_pop)
      buf_data <= i_rdata;
    if (state == CACHE_UPDATE)
    begin
      if (i_membus_write)
      begin
        for (int b = 0; b < `WORD_W / 8; b++)
        begin
          if (i_membus_wr_mask[b])
            buf_data[word_sel * `WORD_W + b * 8 +: 8] <= i_membus_data[b * 8 +: 8];
        end
        o_membus_data <= i_membus_data;
      end
      else
        o_membus_data <= buf_data[word_sel * `WORD_W +: `WORD_W];
    end
  end

  // requester may only raise req once the last ack has fallen
  assert property (@(posedge clk) disable iff (rst)
    $rose(i_membus_req) |-> !o_membus_ack)
    else $error("line_cache_ctrl: req rose while ack still high");

endmodule

/* list.f */
+incdir+.
ddr_pkg.sv
sync_fifo.sv
line_cache_ctrl.sv
avalon_master.sv
ddr_bridge_top.sv
tb_avalon_mem.sv
tb_ddr_bridge.sv

/* sync_fifo.sv */
`include "ddr_settings.svh"

module sync_fifo #(
  parameter int WIDTH      = `LINE_W,
  parameter int DEPTH_LOG2 = `FIFO_DEPTH_LOG2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_pop,
  output logic [WIDTH-1:0] o_data,
  output logic             o_empty,
  output logic             o_full
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  logic [WIDTH-1:0]    mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                do_push;
  logic                do_pop;

  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;

  assign o_empty = (count == '0);
  assign o_full  = (count == (DEPTH_LOG2 + 1)'(DEPTH));

  // first-word fall-through
  assign o_data = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= i_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + (DEPTH_LOG2 + 1)'(do_push) - (DEPTH_LOG2 + 1)'(do_pop);
    end
  end

  // producer and consumer must respect the flags
  assert property (@(posedge clk) disable iff (rst) i_push |-> !o_full)
    else $error("sync_fifo: push while full");

  assert property (@(posedge clk) disable iff (rst) i_pop |-> !o_empty)
    else $error("sync_fifo: pop while empty");

endmodule

/* tb_avalon_mem.sv */
`include "ddr_settings.svh"

module tb_avalon_mem
  import ddr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      i_read,
  input  logic      i_write,
  input  avl_addr_t i_addr,
  input  line_t     i_wdata,
  output logic      o_ready,
  output logic      o_rdata_valid,
  output line_t     o_rdata,
  output int        o_wr_count,
  output avl_addr_t o_last_wr_addr,
  output line_t     o_last_wr_data
);

  line_t     lines [line_addr_t];
  logic      ready        = 1'b0;
  logic      rdata_valid  = 1'b0;
  line_t     rdata        = '0;
  logic      pending      = 1'b0;
  int        delay        = 0;
  avl_addr_t rd_addr      = '0;
  int        wr_count     = 0;
  avl_addr_t last_wr_addr = '0;
  line_t     last_wr_data = '0;

  assign o_ready        = ready;
  assign o_rdata_valid  = rdata_valid;
  assign o_rdata        = rdata;
  assign o_wr_count     = wr_count;
  assign o_last_wr_addr = last_wr_addr;
  assign o_last_wr_data = last_wr_data;

  // each word holds its own byte address with a marker
  function automatic line_t init_line(input avl_addr_t addr);
    line_t     l;
    avl_addr_t wa;
    for (int w = 0; w < 4; w++)
    begin
      wa = {addr[`DDR_ADDR_W-1:4], 2'(w), 2'b00};
      l[w * 32 +: 32] = 32'(wa) ^ 32'h5a5a_0000;
    end
    return l;
  endfunction

  function automatic line_t read_line(input avl_addr_t addr);
    if (lines.exists(addr[`DDR_ADDR_W-1:4]))
      return lines[addr[`DDR_ADDR_W-1:4]];
    return init_line(addr);
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      ready       <= 1'b0;
      rdata_valid <= 1'b0;
      pending     <= 1'b0;
    end
    else
    begin
      rdata_valid <= 1'b0;
      // stall roughly one cycle in four
      ready <= (($urandom % 4) != 0);
      if ((i_read || i_write) && ready)
      begin
        if (i_write)
        begin
          lines[i_addr[`DDR_ADDR_W-1:4]] = i_wdata;
          wr_count     <= wr_count + 1;
          last_wr_addr <= i_addr;
          last_wr_data <= i_wdata;
        end
        else
        begin
          pending <= 1'b1;
          delay   <= 1 + int'($urandom % 6);
          rd_addr <= i_addr;
        end
      end
      if (pending)
      begin
        if (delay <= 1)
        begin
          rdata_valid <= 1'b1;
          rdata       <= read_line(rd_addr);
          pending     <= 1'b0;
        end
        else
          delay <= delay - 1;
      end
    end
  end

endmodule

/* tb_ddr_bridge.sv */
`include "ddr_settings.svh"

module tb_ddr_bridge
  import ddr_pkg::*;
();

  localparam int RANDOM_TXNS    = 2000;
  localparam int DIRECTED_TXNS  = 16;
  localparam int TOTAL_TXNS     = RANDOM_TXNS + DIRECTED_TXNS;
  localparam int CYCLES_PER_TXN = 200;
  localparam logic [31:0] SEED  = 32'hd984_66f0;

  localparam line_addr_t LINE_A    = 22'h01234;
  localparam line_addr_t LINE_B    = 22'h2f0c1;
  localparam line_addr_t RAND_BASE = 22'h00400;

  logic       clk;
  logic       rst;
  logic       membus_req;
  logic       membus_write;
  word_t      membus_addr;
  word_t      membus_wdata;
  byte_mask_t membus_mask;
  logic       membus_ack;
  word_t      membus_rdata;

  logic       avl_ready;
  logic       avl_rdata_valid;
  line_t      avl_rdata;
  logic       avl_read;
  logic       avl_write;
  avl_addr_t  avl_addr;
  line_t      avl_wdata;

  int         wr_count;
  avl_addr_t  last_wr_addr;
  line_t      last_wr_data;

  // expected memory contents, keyed by word address
  word_t      shadow [logic [23:0]];
  logic       chk_read      = 1'b0;
  word_t      chk_exp       = '0;
  logic       ack_prev      = 1'b0;

  ddr_bridge_top ddr_bridge_top_i (
    .clk               (clk),
    .rst               (rst),
    .i_membus_req      (membus_req),
    .i_membus_write    (membus_write),
    .i_membus_addr     (membus_addr),
    .i_membus_data     (membus_wdata),
    .i_membus_wr_mask  (membus_mask),
    .o_membus_ack      (membus_ack),
    .o_membus_data     (membus_rdata),
    .i_avl_ready       (avl_ready),
    .i_avl_rdata_valid (avl_rdata_valid),
    .i_avl_rdata       (avl_rdata),
    .o_avl_read        (avl_read),
    .o_avl_write       (avl_write),
    .o_avl_addr        (avl_addr),
    .o_avl_wdata       (avl_wdata)
  );

  tb_avalon_mem avalon_mem_i (
    .clk            (clk),
    .rst            (rst),
    .i_read         (avl_read),
    .i_write        (avl_write),
    .i_addr         (avl_addr),
    .i_wdata        (avl_wdata),
    .o_ready        (avl_ready),
    .o_rdata_valid  (avl_rdata_valid),
    .o_rdata        (avl_rdata),
    .o_wr_count     (wr_count),
    .o_last_wr_addr (last_wr_addr),
    .o_last_wr_data (last_wr_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic word_t word_at(input line_addr_t line, input logic [1:0] w);
    return {6'b0, line, w, 2'b00};
  endfunction

  // last written value, else the memory's init pattern
  function automatic word_t ref_read(input word_t addr);
    logic [23:0] key;
    key = addr[25:2];
    if (shadow.exists(key))
      return shadow[key];
    return {6'b0, addr[25:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t data,
                                        input byte_mask_t mask);
    word_t res;
    res = old;
    for (int b = 0; b < 4; b++)
    begin
      if (mask[b])
        res[b * 8 +: 8] = data[b * 8 +: 8];
    end
    return res;
  endfunction

  function automatic line_t line_image(input line_addr_t line);
    line_t l;
    for (int w = 0; w < 4; w++)
      l[w * 32 +: 32] = ref_read(word_at(line, 2'(w)));
    return l;
  endfunction

  task automatic check_eq(input string name, input logic [127:0] got,
                          input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("error: %s got %0h expected %0h", name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // one full four-phase handshake on the word bus
  task automatic access(input logic write, input word_t addr, input word_t data,
                        input byte_mask_t mask, output int sample_to_ack);
    int cycles;
    cycles   = 0;
    chk_read = !write;
    if (!write)
      chk_exp = ref_read(addr);
    membus_req   <= 1'b1;
    membus_write <= write;
    membus_addr  <= addr;
    membus_wdata <= data;
    membus_mask  <= mask;
    do
    begin
      @(posedge clk);
      cycles++;
    end
    while (!membus_ack);
    membus_req <= 1'b0;
    if (write)
      shadow[addr[25:2]] = merge_bytes(ref_read(addr), data, mask);
    do
      @(posedge clk);
    while (membus_ack);
    sample_to_ack = cycles - 1;
  endtask

  // read data is compared when ack rises
  always @(posedge clk)
  begin
    if (membus_ack && !ack_prev && chk_read)
      check_eq("o_membus_data", 128'(membus_rdata), 128'(chk_exp));
    ack_prev <= membus_ack;
  end

  initial
  begin
    repeat (TOTAL_TXNS * CYCLES_PER_TXN) @(posedge clk);
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout, the transactions did not finish within %0d cycles",
           TOTAL_TXNS * CYCLES_PER_TXN);
  end

  initial
  begin
    int         lat;
    int         wr_before;
    line_t      old_line;
    line_addr_t line;
    word_t      addr;
    word_t      data;
    byte_mask_t mask;
    logic       write;

    void'($urandom(SEED));
    rst          = 1'b1;
    membus_req   = 1'b0;
    membus_write = 1'b0;
    membus_addr  = '0;
    membus_wdata = '0;
    membus_mask  = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    repeat (5)
    begin
      @(posedge clk);
      check_eq("o_membus_ack", 128'(membus_ack), 128'(0));
      check_eq("o_avl_read", 128'(avl_read), 128'(0));
      check_eq("o_avl_write", 128'(avl_write), 128'(0));
    end

    // cold miss, then a hit in the same line
    access(1'b0, word_at(LINE_A, 2'd1), '0, '0, lat);
    access(1'b0, word_at(LINE_A, 2'd3), '0, '0, lat);

    access(1'b1, word_at(LINE_A, 2'd2), 32'hcafe_f00d, 4'hf, lat);
    access(1'b0, word_at(LINE_A, 2'd2), '0, '0, lat);
    check_eq("hit ack latency", 128'(lat), 128'(2));

    // partial masks on written and on untouched words
    access(1'b1, word_at(LINE_A, 2'd0), 32'h1122_3344, 4'b0101, lat);
    access(1'b0, word_at(LINE_A, 2'd0), '0, '0, lat);
    access(1'b1, word_at(LINE_A, 2'd2), 32'haabb_ccdd, 4'b1000, lat);
    access(1'b0, word_at(LINE_A, 2'd2), '0, '0, lat);

    // eviction writes the old line back once
    old_line  = line_image(LINE_A);
    wr_before = wr_count;
    access(1'b0, word_at(LINE_B, 2'd0), '0, '0, lat);
    check_eq("write-back count", 128'(wr_count), 128'(wr_before + 1));
    check_eq("o_avl_addr", 128'(last_wr_addr), 128'({LINE_A, 4'b0000}));
    check_eq("o_avl_wdata", 128'(last_wr_data), 128'(old_line));

    old_line  = line_image(LINE_B);
    wr_before = wr_count;
    for (int w = 0; w < 4; w++)
      access(1'b0, word_at(LINE_A, 2'(w)), '0, '0, lat);
    check_eq("write-back count", 128'(wr_count), 128'(wr_before + 1));
    check_eq("o_avl_addr", 128'(last_wr_addr), 128'({LINE_B, 4'b0000}));
    check_eq("o_avl_wdata", 128'(last_wr_data), 128'(old_line));

    for (int i = 0; i < RANDOM_TXNS; i++)
    begin
      line  = RAND_BASE + 22'($urandom % 8);
      addr  = word_at(line, 2'($urandom % 4));
      write = (($urandom % 2) == 1);
      data  = $urandom;
      mask  = 4'($urandom % 16);
      access(write, addr, data, mask, lat);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
